// ==== hw/isa_pkg.sv ====
// isa_pkg
// Architectural definitions for the execute block: the data word,
// the integer ALU function codes and the branch condition encoding.

package isa_pkg;

    //////////////////////////////////////////////////
    // data word
    //////////////////////////////////////////////////
    typedef logic [63:0] word_t;   // operands and results

    //////////////////////////////////////////////////
    // alu functions
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADDQ   = 4'h0,
        ALU_SUBQ   = 4'h1,
        ALU_AND    = 4'h2,
        ALU_BIC    = 4'h3,   // a & ~b
        ALU_BIS    = 4'h4,   // a | b
        ALU_ORNOT  = 4'h5,
        ALU_XOR    = 4'h6,
        ALU_EQV    = 4'h7,   // a ^ ~b
        ALU_SRL    = 4'h8,
        ALU_SLL    = 4'h9,
        ALU_SRA    = 4'ha,
        ALU_CMPULT = 4'hb,
        ALU_CMPEQ  = 4'hc,
        ALU_CMPULE = 4'hd,
        ALU_CMPLT  = 4'he,
        ALU_CMPLE  = 4'hf
    } alu_func_e;

    //////////////////////////////////////////////////
    // branch conditions
    //////////////////////////////////////////////////
    // bit 2 inverts the outcome, bits 1:0 pick the test
    typedef logic [2:0] br_cond_t;

    localparam logic [1:0] BR_LBC = 2'b00;   // low bit clear
    localparam logic [1:0] BR_EQ  = 2'b01;   // equal to zero
    localparam logic [1:0] BR_LT  = 2'b10;   // negative
    localparam logic [1:0] BR_LE  = 2'b11;   // negative or zero

endpackage

// ==== hw/uarch_pkg.sv ====
// uarch_pkg
// Microarchitectural definitions: register and reorder-buffer tags,
// the issue records for both lanes and the completed result record.

package uarch_pkg;

    localparam int PRF_TAG_W = 6;
    localparam int ROB_IDX_W = 5;

    typedef logic [PRF_TAG_W-1:0] prf_tag_t;   // physical dest register
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;   // reorder buffer slot

    // one alu / branch operation
    typedef struct packed {
        isa_pkg::word_t     opa;
        isa_pkg::word_t     opb;
        isa_pkg::alu_func_e func;
        logic               is_branch;
        isa_pkg::br_cond_t  cond;
        logic               pred_taken;
        prf_tag_t           dest_tag;
        rob_idx_t           rob_idx;
    } alu_issue_t;

    // one multiply
    typedef struct packed {
        isa_pkg::word_t mcand;
        isa_pkg::word_t mplier;
        prf_tag_t       dest_tag;
        rob_idx_t       rob_idx;
    } mult_issue_t;

    // what goes on the result bus
    typedef struct packed {
        isa_pkg::word_t value;
        prf_tag_t       dest_tag;
        rob_idx_t       rob_idx;
        logic           is_branch;
        logic           taken;
        logic           mispredict;
    } fu_result_t;

endpackage

// ==== hw/alu_lane.sv ====
// alu_lane
// Integer ALU lane. Computes one of sixteen ALU functions, evaluates
// the branch condition on opa and flags a mispredict, then holds the
// result in an output register until the completion arbiter grants it.

`timescale 1ns/1ps

module alu_lane (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  uarch_pkg::alu_issue_t  issue,
    output logic                   ready,
    output logic                   res_valid,
    output uarch_pkg::fu_result_t  res,
    input  logic                   grant
);

    isa_pkg::word_t alu_result;
    logic [5:0]     shamt;
    logic [6:0]     fill_shamt;     // 64 - shamt, for sra sign fill
    logic           cond_hit;
    logic           taken;
    logic           mispredict;
    logic           load;

    // signs equal: unsigned compare works, otherwise the negative one is smaller
    function automatic logic signed_lt(input isa_pkg::word_t a, input isa_pkg::word_t b);
        if (a[63] == b[63])
            return a < b;
        else
            return a[63];
    endfunction

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    assign shamt      = issue.opb[5:0];
    assign fill_shamt = 7'd64 - {1'b0, shamt};   // 64 when shamt is 0, fill vanishes

    always_comb
    begin
        case (issue.func)
            isa_pkg::ALU_ADDQ:   alu_result = issue.opa + issue.opb;
            isa_pkg::ALU_SUBQ:   alu_result = issue.opa - issue.opb;
            isa_pkg::ALU_AND:    alu_result = issue.opa & issue.opb;
            isa_pkg::ALU_BIC:    alu_result = issue.opa & ~issue.opb;
            isa_pkg::ALU_BIS:    alu_result = issue.opa | issue.opb;
            isa_pkg::ALU_ORNOT:  alu_result = issue.opa | ~issue.opb;
            isa_pkg::ALU_XOR:    alu_result = issue.opa ^ issue.opb;
            isa_pkg::ALU_EQV:    alu_result = issue.opa ^ ~issue.opb;
            isa_pkg::ALU_SRL:    alu_result = issue.opa >> shamt;
            isa_pkg::ALU_SLL:    alu_result = issue.opa << shamt;
            isa_pkg::ALU_SRA:    alu_result = (issue.opa >> shamt) |
                                              ({64{issue.opa[63]}} << fill_shamt);
            isa_pkg::ALU_CMPULT: alu_result = {63'd0, issue.opa < issue.opb};
            isa_pkg::ALU_CMPEQ:  alu_result = {63'd0, issue.opa == issue.opb};
            isa_pkg::ALU_CMPULE: alu_result = {63'd0, issue.opa <= issue.opb};
            isa_pkg::ALU_CMPLT:  alu_result = {63'd0, signed_lt(issue.opa, issue.opb)};
            isa_pkg::ALU_CMPLE:  alu_result = {63'd0, signed_lt(issue.opa, issue.opb) ||
                                                      (issue.opa == issue.opb)};
            default:             alu_result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // branch condition
    //////////////////////////////////////////////////
    always_comb
    begin
        case (issue.cond[1:0])
            isa_pkg::BR_LBC: cond_hit = ~issue.opa[0];
            isa_pkg::BR_EQ:  cond_hit = (issue.opa == '0);
            isa_pkg::BR_LT:  cond_hit = issue.opa[63];
            default:         cond_hit = issue.opa[63] | (issue.opa == '0);   // le
        endcase
    end

    assign taken      = issue.is_branch & (cond_hit ^ issue.cond[2]);
    assign mispredict = issue.is_branch & (taken ^ issue.pred_taken);

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////
    assign ready = ~res_valid | grant;     // free or draining this cycle
    assign load  = issue_valid & ready;

    always_ff @(posedge clock)
    begin
        if (reset)
            res_valid <= 1'b0;
        else if (load)
            res_valid <= 1'b1;
        else if (grant)
            res_valid <= 1'b0;
    end

    always_ff @(posedge clock)
    begin
        if (load)
        begin
            res.value      <= alu_result;
            res.dest_tag   <= issue.dest_tag;
            res.rob_idx    <= issue.rob_idx;
            res.is_branch  <= issue.is_branch;
            res.taken      <= taken;
            res.mispredict <= mispredict;
        end
    end

endmodule

// ==== hw/mult_lane.sv ====
// mult_lane
// Pipelined 64-bit multiplier. Each of MULT_STAGES stages multiplies
// the multiplicand by one slice of the multiplier and adds the shifted
// partial product to a running low-64-bit sum. The whole pipe advances
// only when the output register is empty or being granted.

`timescale 1ns/1ps

module mult_lane #(
    parameter int MULT_STAGES = 4   // 1, 2, 4 or 8
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  uarch_pkg::mult_issue_t issue,
    output logic                   ready,
    output logic                   res_valid,
    output uarch_pkg::fu_result_t  res,
    input  logic                   grant
);

    localparam int SLICE_W = 64 / MULT_STAGES;

    typedef struct packed {
        isa_pkg::word_t      mcand;
        isa_pkg::word_t      mplier;
        isa_pkg::word_t      sum;       // low 64 bits so far
        uarch_pkg::prf_tag_t dest_tag;
        uarch_pkg::rob_idx_t rob_idx;
    } mult_stage_t;

    logic                     advance;
    logic [MULT_STAGES:0]     valid_chain;
    logic [MULT_STAGES-1:0]   pipe_valid;
    mult_stage_t              stage_next [MULT_STAGES];
    mult_stage_t              pipe_q     [MULT_STAGES];   // last entry is the output reg

    assign advance = ~pipe_valid[MULT_STAGES-1] | grant;
    assign ready   = advance;

    //////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////
    for (genvar k = 0; k < MULT_STAGES; k++)
    begin : g_stage
        mult_stage_t          stage_in;
        logic [SLICE_W-1:0]   slice;
        isa_pkg::word_t       partial;

        if (k == 0)
        begin : g_first
            assign stage_in = '{mcand: issue.mcand, mplier: issue.mplier, sum: '0,
                                dest_tag: issue.dest_tag, rob_idx: issue.rob_idx};
        end
        else
        begin : g_rest
            assign stage_in = pipe_q[k-1];
        end

        assign slice   = stage_in.mplier[k*SLICE_W +: SLICE_W];
        assign partial = stage_in.mcand * isa_pkg::word_t'(slice);  // truncated to 64

        always_comb
        begin
            stage_next[k]     = stage_in;
            stage_next[k].sum = stage_in.sum + (partial << (k * SLICE_W));
        end
    end

    //////////////////////////////////////////////////
    // pipe registers
    //////////////////////////////////////////////////
    assign valid_chain = {pipe_valid, issue_valid};

    always_ff @(posedge clock)
    begin
        if (reset)
            pipe_valid <= '0;
        else if (advance)
            pipe_valid <= valid_chain[MULT_STAGES-1:0];   // shift in new issue
    end

    always_ff @(posedge clock)
    begin
        if (advance)
        begin
            for (int k = 0; k < MULT_STAGES; k++)
                pipe_q[k] <= stage_next[k];
        end
    end

    // output view of the last register
    assign res_valid = pipe_valid[MULT_STAGES-1];

    always_comb
    begin
        res            = '0;
        res.value      = pipe_q[MULT_STAGES-1].sum;
        res.dest_tag   = pipe_q[MULT_STAGES-1].dest_tag;
        res.rob_idx    = pipe_q[MULT_STAGES-1].rob_idx;
    end

endmodule

// ==== hw/completion_arbiter.sv ====
// completion_arbiter
// Merges the ALU and multiplier results onto one registered result
// bus. Round-robin between the lanes when both are waiting; a lone
// requester is granted whenever the bus can take it.

`timescale 1ns/1ps

module completion_arbiter (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alu_valid,
    input  logic                  mult_valid,
    input  uarch_pkg::fu_result_t alu_res,
    input  uarch_pkg::fu_result_t mult_res,
    output logic                  alu_grant,
    output logic                  mult_grant,
    output logic                  cdb_valid,
    output uarch_pkg::fu_result_t cdb,
    input  logic                  cdb_accept
);

    logic bus_free;
    logic mult_first;    // mult takes the next tie when set
    logic contested;

    assign bus_free  = ~cdb_valid | cdb_accept;
    assign contested = alu_valid & mult_valid;

    assign alu_grant  = bus_free & alu_valid  & (~mult_valid | ~mult_first);
    assign mult_grant = bus_free & mult_valid & (~alu_valid  |  mult_first);

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            cdb_valid  <= 1'b0;
            mult_first <= 1'b0;
        end
        else
        begin
            if (alu_grant | mult_grant)
                cdb_valid <= 1'b1;
            else if (cdb_accept)
                cdb_valid <= 1'b0;

            if (contested & bus_free)
                mult_first <= ~mult_first;   // flip after every tie
        end
    end

    // bus payload held until accepted
    always_ff @(posedge clock)
    begin
        if (alu_grant | mult_grant)
            cdb <= mult_grant ? mult_res : alu_res;
    end

endmodule

// ==== hw/exec_unit.sv ====
// exec_unit
// Execute block top level. Connects the ALU and multiplier issue
// ports to their lanes and the lanes to the completion arbiter,
// which drives the tagged result bus.

`timescale 1ns/1ps

module exec_unit #(
    parameter int MULT_STAGES = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   alu_issue_valid,
    input  uarch_pkg::alu_issue_t  alu_issue,
    output logic                   alu_ready,
    input  logic                   mult_issue_valid,
    input  uarch_pkg::mult_issue_t mult_issue,
    output logic                   mult_ready,
    output logic                   cdb_valid,
    output uarch_pkg::fu_result_t  cdb,
    input  logic                   cdb_accept
);

    // lane to arbiter links
    logic                  alu_res_valid;
    uarch_pkg::fu_result_t alu_res;
    logic                  alu_grant;
    logic                  mult_res_valid;
    uarch_pkg::fu_result_t mult_res;
    logic                  mult_grant;

    alu_lane alu_lane_inst (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (alu_issue_valid),
        .issue       (alu_issue),
        .ready       (alu_ready),
        .res_valid   (alu_res_valid),
        .res         (alu_res),
        .grant       (alu_grant)
    );

    mult_lane #(
        .MULT_STAGES (MULT_STAGES)
    ) mult_lane_inst (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (mult_issue_valid),
        .issue       (mult_issue),
        .ready       (mult_ready),
        .res_valid   (mult_res_valid),
        .res         (mult_res),
        .grant       (mult_grant)
    );

    completion_arbiter completion_arbiter_inst (
        .clock       (clock),
        .reset       (reset),
        .alu_valid   (alu_res_valid),
        .mult_valid  (mult_res_valid),
        .alu_res     (alu_res),
        .mult_res    (mult_res),
        .alu_grant   (alu_grant),
        .mult_grant  (mult_grant),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .cdb_accept  (cdb_accept)
    );

endmodule

// ==== tb/exec_ref.svh ====
// exec_ref
// Reference model for the execute block testbench: ALU results from
// the arithmetic meaning of each function, branch outcomes and the
// low half of a 64 x 64 product.

`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

function automatic isa_pkg::word_t ref_alu(input isa_pkg::alu_func_e func,
                                           input isa_pkg::word_t a,
                                           input isa_pkg::word_t b);
    int unsigned sh;
    sh = b[5:0];   // only the low six bits count
    case (func)
        isa_pkg::ALU_ADDQ:   return a + b;
        isa_pkg::ALU_SUBQ:   return a - b;
        isa_pkg::ALU_AND:    return a & b;
        isa_pkg::ALU_BIC:    return a & ~b;
        isa_pkg::ALU_BIS:    return a | b;
        isa_pkg::ALU_ORNOT:  return a | ~b;
        isa_pkg::ALU_XOR:    return a ^ b;
        isa_pkg::ALU_EQV:    return ~(a ^ b);
        isa_pkg::ALU_SRL:    return a >> sh;
        isa_pkg::ALU_SLL:    return a << sh;
        isa_pkg::ALU_SRA:    return $signed(a) >>> sh;
        isa_pkg::ALU_CMPULT: return (a < b) ? 64'd1 : 64'd0;
        isa_pkg::ALU_CMPEQ:  return (a == b) ? 64'd1 : 64'd0;
        isa_pkg::ALU_CMPULE: return (a <= b) ? 64'd1 : 64'd0;
        isa_pkg::ALU_CMPLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        isa_pkg::ALU_CMPLE:  return ($signed(a) <= $signed(b)) ? 64'd1 : 64'd0;
        default:             return '0;
    endcase
endfunction

function automatic logic ref_branch_taken(input isa_pkg::br_cond_t cond,
                                          input isa_pkg::word_t a);
    logic hit;
    case (cond[1:0])
        2'd0:    hit = (a[0] == 1'b0);
        2'd1:    hit = (a == 64'd0);
        2'd2:    hit = ($signed(a) < 0);
        default: hit = ($signed(a) <= 0);
    endcase
    return hit ^ cond[2];   // top bit inverts
endfunction

function automatic isa_pkg::word_t ref_mult(input isa_pkg::word_t a, input isa_pkg::word_t b);
    logic [127:0] full;
    full = {64'd0, a} * {64'd0, b};
    return full[63:0];
endfunction

`endif

// ==== tb/exec_unit_tb.sv ====
// exec_unit_tb
// Testbench for the execute block. Drives the ALU and multiplier issue
// ports, keeps a scoreboard keyed by rob_idx and checks every result
// bus transfer against the reference model, including timing, stall
// behavior and round-robin fairness.

`timescale 1ns/1ps

module exec_unit_tb;

    localparam int MULT_STAGES = 4;
    localparam int WAIT_LIMIT  = 2000;   // cycles per wait

    logic                   clock;
    logic                   reset;
    logic                   alu_issue_valid;
    uarch_pkg::alu_issue_t  alu_issue;
    logic                   alu_ready;
    logic                   mult_issue_valid;
    uarch_pkg::mult_issue_t mult_issue;
    logic                   mult_ready;
    logic                   cdb_valid;
    uarch_pkg::fu_result_t  cdb;
    logic                   cdb_accept;

    uarch_pkg::fu_result_t  expected [32];   // scoreboard indexed by rob_idx
    logic                   pending  [32];
    uarch_pkg::fu_result_t  held_cdb;
    logic                   held = 1'b0;
    uarch_pkg::rob_idx_t    next_rob;
    int                     cycle_count = 0;
    int                     issue_cycle;
    int                     issued_at   [32];   // transfer cycle by rob_idx
    bit                     mult_op     [32];   // set for multiplier entries
    int                     xfer_cycles [$];
    int                     accept_mode;     // 0 high, 1 random, 2 low
    integer                 seed = 32'h5ce9_27c7;

    `include "exec_ref.svh"

    exec_unit #(
        .MULT_STAGES (MULT_STAGES)
    ) exec_unit_inst (
        .clock            (clock),
        .reset            (reset),
        .alu_issue_valid  (alu_issue_valid),
        .alu_issue        (alu_issue),
        .alu_ready        (alu_ready),
        .mult_issue_valid (mult_issue_valid),
        .mult_issue       (mult_issue),
        .mult_ready       (mult_ready),
        .cdb_valid        (cdb_valid),
        .cdb              (cdb),
        .cdb_accept       (cdb_accept)
    );

    //////////////////////////////////////////////////
    // reporting and compare tasks
    //////////////////////////////////////////////////
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string field, input logic [63:0] got,
                                   input logic [63:0] exp);
        abort_run($sformatf("** Error at %0t: %s mismatch, got %h expected %h",
                            $time, field, got, exp));
    endtask

    task automatic compare_word(input isa_pkg::word_t got, input isa_pkg::word_t exp,
                                input string field);
        if (got !== exp)
            report_mismatch(field, got, exp);
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string field);
        if (got !== exp)
            report_mismatch(field, got, exp);
    endtask

    task automatic compare_cycles(input int got, input int exp, input string field);
        if (got != exp)
            report_mismatch(field, got, exp);
    endtask

    task automatic check_latency(input int got, input int limit, input string field);
        if (got > limit)
            abort_run($sformatf("** Error at %0t: %s of %0d cycles exceeds %0d",
                                $time, field, got, limit));
    endtask

    task automatic compare_result(input uarch_pkg::fu_result_t got,
                                  input uarch_pkg::fu_result_t exp, input string ctx);
        compare_word(got.value, exp.value, {ctx, " value"});
        if (got.dest_tag !== exp.dest_tag)
            report_mismatch({ctx, " dest_tag"}, got.dest_tag, exp.dest_tag);
        if (got.rob_idx !== exp.rob_idx)
            report_mismatch({ctx, " rob_idx"}, got.rob_idx, exp.rob_idx);
        compare_flag(got.is_branch, exp.is_branch, {ctx, " is_branch"});
        compare_flag(got.taken, exp.taken, {ctx, " taken"});
        compare_flag(got.mispredict, exp.mispredict, {ctx, " mispredict"});
    endtask

    //////////////////////////////////////////////////
    // clock, accept driver, monitor
    //////////////////////////////////////////////////
    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock)
        cycle_count <= cycle_count + 1;   // readers at the edge see the previous count

    always @(posedge clock)
    begin
        #1;
        case (accept_mode)
            0:       cdb_accept = 1'b1;
            1:       cdb_accept = $random(seed);
            default: cdb_accept = 1'b0;
        endcase
    end

    always @(posedge clock)
    begin
        if (reset)
            held = 1'b0;
        else
        begin
            if (held)
            begin
                compare_flag(cdb_valid, 1'b1, "stalled cdb_valid");
                compare_result(cdb, held_cdb, "stalled cdb");
            end
            if (cdb_valid && cdb_accept)
            begin
                if (!pending[cdb.rob_idx])
                    abort_run($sformatf("result for rob_idx %0d arrived with nothing outstanding",
                                        cdb.rob_idx));
                compare_result(cdb, expected[cdb.rob_idx], "cdb");
                // with accept held high a lane loses at most one tie in a row
                // and a multiply may lose one cycle at each stage move
                if (accept_mode == 0)
                    check_latency(cycle_count - issued_at[cdb.rob_idx],
                                  mult_op[cdb.rob_idx] ? 2 * MULT_STAGES + 1 : 3,
                                  mult_op[cdb.rob_idx] ? "multiply latency" : "alu latency");
                pending[cdb.rob_idx] = 1'b0;
                xfer_cycles.push_back(cycle_count);
            end
            held     = cdb_valid && !cdb_accept;
            held_cdb = cdb;
        end
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////
    function automatic isa_pkg::word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < 32; i++)
            n += pending[i];
        return n;
    endfunction

    function automatic uarch_pkg::rob_idx_t alloc_rob();
        alloc_rob = next_rob;
        next_rob++;
    endfunction

    task automatic wait_slot(input uarch_pkg::rob_idx_t idx);
        int waited;
        waited = 0;
        while (pending[idx])
        begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run($sformatf("timed out waiting for rob slot %0d to retire", idx));
        end
    endtask

    // returns at the edge where the transfer happens
    task automatic await_transfer(input bit is_mult);
        int waited;
        waited = 0;
        @(posedge clock);
        while (!(is_mult ? mult_ready : alu_ready))
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run(is_mult ? "timed out waiting for mult_ready"
                                  : "timed out waiting for alu_ready");
            @(posedge clock);
        end
    endtask

    task automatic issue_alu(input isa_pkg::alu_func_e func, input isa_pkg::word_t a,
                             input isa_pkg::word_t b, input bit br,
                             input isa_pkg::br_cond_t cond, input bit pred);
        uarch_pkg::alu_issue_t op;
        uarch_pkg::fu_result_t exp;
        op = '{opa: a, opb: b, func: func, is_branch: br, cond: cond, pred_taken: pred,
               dest_tag: $random(seed), rob_idx: alloc_rob()};
        wait_slot(op.rob_idx);
        exp = '{value: ref_alu(func, a, b), dest_tag: op.dest_tag, rob_idx: op.rob_idx,
                is_branch: br, taken: br & ref_branch_taken(cond, a), mispredict: 1'b0};
        exp.mispredict = br & (exp.taken ^ pred);
        alu_issue       = op;
        alu_issue_valid = 1'b1;
        await_transfer(1'b0);
        expected[op.rob_idx]  = exp;
        pending[op.rob_idx]   = 1'b1;
        issued_at[op.rob_idx] = cycle_count;
        mult_op[op.rob_idx]   = 1'b0;
        issue_cycle           = cycle_count;
        #1;
        alu_issue_valid = 1'b0;
    endtask

    task automatic issue_mult(input isa_pkg::word_t a, input isa_pkg::word_t b);
        uarch_pkg::mult_issue_t op;
        uarch_pkg::fu_result_t  exp;
        op = '{mcand: a, mplier: b, dest_tag: $random(seed), rob_idx: alloc_rob()};
        wait_slot(op.rob_idx);
        exp = '{value: ref_mult(a, b), dest_tag: op.dest_tag, rob_idx: op.rob_idx,
                is_branch: 1'b0, taken: 1'b0, mispredict: 1'b0};
        mult_issue       = op;
        mult_issue_valid = 1'b1;
        await_transfer(1'b1);
        expected[op.rob_idx]  = exp;
        pending[op.rob_idx]   = 1'b1;
        issued_at[op.rob_idx] = cycle_count;
        mult_op[op.rob_idx]   = 1'b1;
        issue_cycle           = cycle_count;
        #1;
        mult_issue_valid = 1'b0;
    endtask

    task automatic wait_drain(input string phase);
        int waited;
        waited = 0;
        while (pending_count() != 0)
        begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run({"timed out waiting for the scoreboard to drain after ", phase});
        end
    endtask

    task automatic wait_ready_low();
        int waited;
        waited = 0;
        while (alu_ready || mult_ready)
        begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("ready outputs never fell while the result bus was stalled");
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial
    begin
        isa_pkg::word_t ev [5];
        int             first_issue;
        reset            = 1'b1;
        alu_issue_valid  = 1'b0;
        alu_issue        = '0;
        mult_issue_valid = 1'b0;
        mult_issue       = '0;
        cdb_accept       = 1'b1;
        accept_mode      = 0;
        next_rob         = '0;
        for (int i = 0; i < 32; i++)
            pending[i] = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        // state right after reset
        compare_flag(cdb_valid, 1'b0, "cdb_valid after reset");
        compare_flag(alu_ready, 1'b1, "alu_ready after reset");
        compare_flag(mult_ready, 1'b1, "mult_ready after reset");

        // every alu function on edge and random operands
        ev[0] = '0;
        ev[1] = '1;
        ev[2] = 64'h8000_0000_0000_0000;
        ev[3] = 64'd63;   // largest shift amount
        for (int f = 0; f < 16; f++)
            for (int i = 0; i < 5; i++)
                for (int j = 0; j < 6; j++)
                begin
                    ev[4] = rand_word();
                    issue_alu(isa_pkg::alu_func_e'(f), (j == 5) ? rand_word() : ev[i],
                              (j == 5) ? rand_word() : ev[j], 1'b0, 3'd0, 1'b0);
                end
        wait_drain("alu functions");

        // branches over all conditions and both predictions
        ev[1] = 64'd1;
        ev[3] = '1;
        for (int c = 0; c < 8; c++)
            for (int p = 0; p < 2; p++)
                for (int i = 0; i < 5; i++)
                begin
                    ev[4] = rand_word();
                    issue_alu(isa_pkg::alu_func_e'($random(seed) & 15), ev[i], rand_word(),
                              1'b1, c, p);
                end
        wait_drain("branches");

        // back-to-back multiplies with latency and spacing
        xfer_cycles.delete();
        for (int n = 0; n < 12; n++)
        begin
            issue_mult(rand_word(), rand_word());
            if (n == 0)
                first_issue = issue_cycle;
        end
        wait_drain("back-to-back multiplies");
        compare_cycles(xfer_cycles[0] - first_issue, MULT_STAGES + 1, "first multiply latency");
        for (int n = 1; n < 12; n++)
            compare_cycles(xfer_cycles[n] - xfer_cycles[n-1], 1, "multiply result spacing");

        // stall the bus then drain with random accept
        accept_mode = 2;
        @(posedge clock);
        #1;
        issue_alu(isa_pkg::ALU_ADDQ, rand_word(), rand_word(), 1'b0, 3'd0, 1'b0);
        issue_alu(isa_pkg::ALU_XOR, rand_word(), rand_word(), 1'b0, 3'd0, 1'b0);
        issue_mult(rand_word(), rand_word());
        issue_mult(rand_word(), rand_word());
        wait_ready_low();
        repeat (6) @(posedge clock);
        #1;
        accept_mode = 1;
        for (int n = 0; n < 60; n++)
            if ($random(seed) & 1)
                issue_alu(isa_pkg::alu_func_e'($random(seed) & 15), rand_word(), rand_word(),
                          $random(seed), $random(seed), $random(seed));
            else
                issue_mult(rand_word(), rand_word());
        wait_drain("random accept traffic");

        // both lanes busy at once
        accept_mode = 0;
        fork
            for (int n = 0; n < 150; n++)
                issue_alu(isa_pkg::alu_func_e'($random(seed) & 15), rand_word(), rand_word(),
                          $random(seed), $random(seed), $random(seed));
            for (int n = 0; n < 100; n++)
                issue_mult(rand_word(), rand_word());
        join
        wait_drain("mixed traffic");

        if (pending_count() == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
            abort_run("scoreboard not empty at end of test");
    end

endmodule

// ==== exec_unit.f ====
+incdir+tb
hw/isa_pkg.sv
hw/uarch_pkg.sv
hw/alu_lane.sv
hw/mult_lane.sv
hw/completion_arbiter.sv
hw/exec_unit.sv
tb/exec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  - files:
      - hw/isa_pkg.sv
      - hw/uarch_pkg.sv
      - hw/alu_lane.sv
      - hw/mult_lane.sv
      - hw/completion_arbiter.sv
      - hw/exec_unit.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/exec_unit_tb.sv
